//--- Makefile
BUILD = build

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_kbd_bus \
		-Mdir $(BUILD) -o tb_kbd_bus
	@out="$$(./$(BUILD)/tb_kbd_bus)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(BUILD)

//--- bench/kbd_bus_chk.sv
`timescale 1ns/1ps

module kbd_bus_chk (
    input logic                           clk,
    input logic                           rst_n,
    input logic [soc_map_pkg::BUS_AW-1:0] bus_address,
    input logic                           bus_write_enable,
    input logic [kbd_pkg::IRQ_W-1:0]      irq_vector,
    input logic                           uart_write
);
    import soc_map_pkg::*;

    irq_one_shot: assert property (@(posedge clk) disable iff (!rst_n)
        (irq_vector != '0) |=> (irq_vector == '0))
        else $error("irq_vector nonzero on two consecutive cycles");

    uart_one_shot: assert property (@(posedge clk) disable iff (!rst_n)
        uart_write |=> !uart_write)
        else $error("uart_write high on two consecutive cycles");

    // Console strobe needs a write to the console address
    uart_source: assert property (@(posedge clk) disable iff (!rst_n)
        uart_write |-> (bus_write_enable && bus_address == CON_ADDR))
        else $error("uart_write without a write to the console address");

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (irq_vector == '0 && !uart_write))
        else $error("irq_vector or uart_write active during reset");

endmodule

bind kbd_bus_top kbd_bus_chk chk0 (
    .clk              (CLOCK_50),
    .rst_n            (KEY0),
    .bus_address      (bus_address),
    .bus_write_enable (bus_write_enable),
    .irq_vector       (irq_vector),
    .uart_write       (uart_write)
);

//--- bench/tb_kbd_bus.sv
`timescale 1ns/1ps

module tb_kbd_bus;
    import soc_map_pkg::*;
    import kbd_pkg::*;

    localparam int HALF_BIT = 5;
    localparam int IRQ_LATENCY = 6;
    // Ten frames of about 118 cycles plus bus traffic, doubled and rounded up
    localparam int MAX_CYCLES = 4000;

    // Set-2 make codes in the order of the characters in ref_ascii
    localparam logic [7:0] SCAN_CODES [38] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
        8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A, 8'h45, 8'h16, 8'h1E, 8'h26,
        8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46, 8'h29, 8'h5A
    };

    logic CLOCK_50;
    logic KEY0;
    logic PS2_CLK;
    logic PS2_DAT;
    logic [BUS_AW-1:0] bus_address;
    logic [BUS_DW-1:0] bus_write_data;
    logic bus_write_enable;
    logic bus_read_enable;
    logic [BUS_DW-1:0] bus_read_data;
    logic [IRQ_W-1:0] irq_vector;
    logic [7:0] uart_data;
    logic uart_write;

    int cycle;
    int errors;
    int timeouts;
    int irq_count;
    int uart_count;
    int exp_irq;
    int stop_cycle;
    int seed;
    logic [7:0] exp_key;
    logic brk_seen;
    logic ext_seen;
    logic [31:0] shadow_ram [int];
    logic [7:0] uart_q [$];

    kbd_bus_top dut0 (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .PS2_CLK          (PS2_CLK),
        .PS2_DAT          (PS2_DAT),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .irq_vector       (irq_vector),
        .uart_data        (uart_data),
        .uart_write       (uart_write)
    );

    always #50 CLOCK_50 = ~CLOCK_50;

    always @(posedge CLOCK_50) begin
        cycle <= cycle + 1;
    end

    function automatic logic [7:0] ref_ascii(input logic [7:0] code);
        string chars;
        logic [7:0] result;
        int i;
        chars = "abcdefghijklmnopqrstuvwxyz0123456789 \r";
        result = 8'h00;
        for (i = 0; i < 38; i++) begin
            if (SCAN_CODES[i] == code) begin
                result = chars[i];
            end
        end
        return result;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_and_finish();
        $display("Closing: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    // Start, data LSB first, odd parity, stop
    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        int i;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        @(posedge CLOCK_50);
        for (i = 0; i < 11; i++) begin
            PS2_DAT <= bits[i];
            repeat (HALF_BIT) @(posedge CLOCK_50);
            PS2_CLK <= 1'b0;
            // Count includes this edge
            stop_cycle = cycle + 1;
            repeat (HALF_BIT) @(posedge CLOCK_50);
            PS2_CLK <= 1'b1;
        end
    endtask

    // Expected key register and interrupt count from the prefix rules
    task automatic model_frame(input logic [7:0] code, input logic bad_parity);
        if (bad_parity) begin
            brk_seen = 1'b0;
            ext_seen = 1'b0;
        end else if (code == BREAK_CODE) begin
            brk_seen = 1'b1;
        end else if (code == EXT_CODE) begin
            ext_seen = 1'b1;
        end else begin
            if (!brk_seen && !ext_seen) begin
                exp_key = ref_ascii(code);
                if (exp_key != 8'h00) begin
                    exp_irq++;
                end
            end
            brk_seen = 1'b0;
            ext_seen = 1'b0;
        end
    endtask

    task automatic key_frame(input logic [7:0] code, input logic bad_parity);
        send_frame(code, bad_parity);
        model_frame(code, bad_parity);
        repeat (IRQ_LATENCY + 2) @(posedge CLOCK_50);
        check_eq("irq_vector pulses", irq_count, exp_irq);
    endtask

    task automatic bus_write(input logic [BUS_AW-1:0] addr, input logic [BUS_DW-1:0] data,
                             input int hold);
        @(posedge CLOCK_50);
        bus_address <= addr;
        bus_write_data <= data;
        bus_write_enable <= 1'b1;
        repeat (hold) @(posedge CLOCK_50);
        bus_write_enable <= 1'b0;
    endtask

    task automatic bus_read(input logic [BUS_AW-1:0] addr, output logic [BUS_DW-1:0] data);
        @(posedge CLOCK_50);
        bus_address <= addr;
        bus_read_enable <= 1'b1;
        @(posedge CLOCK_50);
        bus_read_enable <= 1'b0;
        @(negedge CLOCK_50);
        data = bus_read_data;
    endtask

    task automatic check_key();
        logic [BUS_DW-1:0] rdata;
        bus_read(KEY_ADDR, rdata);
        check_eq("bus_read_data", rdata, {56'b0, exp_key});
    endtask

    // Pulse counter and checker, sampled mid-cycle
    always @(negedge CLOCK_50) begin
        if (KEY0) begin
            if (irq_vector != '0) begin
                irq_count++;
                check_eq("irq_vector", irq_vector, KEY_IRQ_VEC);
                check_eq("irq_vector latency", cycle - stop_cycle, IRQ_LATENCY);
            end
            if (uart_write) begin
                uart_count++;
                if (uart_q.size() == 0) begin
                    errors++;
                    $display("uart_write pulsed at %0t ns with no console write pending", $time);
                end else begin
                    check_eq("uart_data", uart_data, uart_q.pop_front());
                end
            end
        end
    end

    initial begin
        wait (cycle >= MAX_CYCLES);
        timeouts++;
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        report_and_finish();
    end

    initial begin
        logic [31:0] r;
        logic [BUS_AW-1:0] addr;
        logic [BUS_DW-1:0] wdata;
        logic [BUS_DW-1:0] rdata;
        int n;
        CLOCK_50 = 1'b0;
        KEY0 = 1'b0;
        PS2_CLK = 1'b1;
        PS2_DAT = 1'b1;
        bus_address = '0;
        bus_write_data = '0;
        bus_write_enable = 1'b0;
        bus_read_enable = 1'b0;
        seed = 89;
        exp_key = 8'h00;
        brk_seen = 1'b0;
        ext_seen = 1'b0;
        repeat (2) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        // RAM write then read back
        for (n = 0; n < 8; n++) begin
            r = $random(seed);
            addr = RAM_BASE + {52'b0, r[11:2], 2'b00};
            wdata = {$random(seed), $random(seed)};
            shadow_ram[int'(r[11:2])] = wdata[31:0];
            bus_write(addr, wdata, 1);
            bus_read(addr, rdata);
            check_eq("bus_read_data", rdata, {32'b0, shadow_ram[int'(r[11:2])]});
        end

        // Second pass over every word written
        foreach (shadow_ram[idx]) begin
            bus_read(RAM_BASE + 64'(idx * 4), rdata);
            check_eq("bus_read_data", rdata, {32'b0, shadow_ram[idx]});
        end

        bus_read(RAM_BASE + 64'(RAM_WORDS * 4) + 64'h40, rdata);
        check_eq("bus_read_data", rdata, UNMAPPED_DATA);
        bus_read(CON_ADDR, rdata);
        check_eq("bus_read_data", rdata, UNMAPPED_DATA);

        // Held write gives one pulse, then two short writes
        uart_q.push_back(8'h41);
        bus_write(CON_ADDR, 64'h0123_4567_89AB_CD41, 4);
        uart_q.push_back(8'h5A);
        bus_write(CON_ADDR, 64'h0000_0000_0000_015A, 1);
        uart_q.push_back(8'h0D);
        bus_write(CON_ADDR, 64'hFFFF_FFFF_FFFF_FF0D, 2);
        @(posedge CLOCK_50);
        check_eq("uart_write pulses", uart_count, 3);

        key_frame(8'h1C, 1'b0);
        check_key();
        key_frame(8'h3D, 1'b0);
        check_key();
        key_frame(8'h29, 1'b0);
        check_key();

        // Break, extended and bad parity frames leave the register alone
        key_frame(BREAK_CODE, 1'b0);
        key_frame(8'h1C, 1'b0);
        check_key();
        key_frame(EXT_CODE, 1'b0);
        key_frame(8'h1C, 1'b0);
        check_key();
        key_frame(8'h1C, 1'b1);
        check_key();
        key_frame(8'h3D, 1'b0);
        check_key();

        // F1 has no ASCII mapping
        key_frame(8'h05, 1'b0);
        check_key();

        check_eq("irq_vector pulses", irq_count, 4);
        if (uart_q.size() != 0) begin
            errors++;
            $display("%0d console writes never produced a uart_write pulse", uart_q.size());
        end
        report_and_finish();
    end

endmodule

//--- common/kbd_pkg.sv
package kbd_pkg;

    // PS/2 frame: start, 8 data, odd parity, stop
    localparam int PS2_FRAME_BITS = 11;
    localparam int PS2_IDLE_CYCLES = 64;
    localparam int PS2_IDLE_W = $clog2(PS2_IDLE_CYCLES);

    // Set-2 prefix bytes
    localparam logic [7:0] BREAK_CODE = 8'hF0;
    localparam logic [7:0] EXT_CODE = 8'hE0;

    localparam int IRQ_W = 4;
    localparam logic [IRQ_W-1:0] KEY_IRQ_VEC = 4'd1;

    // Set-2 make code to ASCII, 0 for keys without a mapping
    function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
        case (code)
            8'h1C: return "a";
            8'h32: return "b";
            8'h21: return "c";
            8'h23: return "d";
            8'h24: return "e";
            8'h2B: return "f";
            8'h34: return "g";
            8'h33: return "h";
            8'h43: return "i";
            8'h3B: return "j";
            8'h42: return "k";
            8'h4B: return "l";
            8'h3A: return "m";
            8'h31: return "n";
            8'h44: return "o";
            8'h4D: return "p";
            8'h15: return "q";
            8'h2D: return "r";
            8'h1B: return "s";
            8'h2C: return "t";
            8'h3C: return "u";
            8'h2A: return "v";
            8'h1D: return "w";
            8'h22: return "x";
            8'h35: return "y";
            8'h1A: return "z";
            8'h45: return "0";
            8'h16: return "1";
            8'h1E: return "2";
            8'h26: return "3";
            8'h25: return "4";
            8'h2E: return "5";
            8'h36: return "6";
            8'h3D: return "7";
            8'h3E: return "8";
            8'h46: return "9";
            8'h29: return 8'h20;
            8'h5A: return 8'h0D;
            default: return 8'h00;
        endcase
    endfunction

endpackage

//--- common/key_if.sv
`timescale 1ns/1ps

interface key_if;

    // One decoded key event, valid for a single cycle
    logic [7:0] scan;
    logic [7:0] ascii;
    logic       make;
    logic       brk;
    logic       valid;

    modport src (
        output scan,
        output ascii,
        output make,
        output brk,
        output valid
    );

    modport dst (
        input scan,
        input ascii,
        input make,
        input brk,
        input valid
    );

endinterface

//--- common/soc_map_pkg.sv
package soc_map_pkg;

    // Bus widths
    localparam int BUS_AW = 64;
    localparam int BUS_DW = 64;

    // Word RAM, 4 KB starting at the bottom of the map
    localparam logic [BUS_AW-1:0] RAM_BASE = 64'h0000_0000_0000_0000;
    localparam int RAM_WORDS = 1024;
    localparam int RAM_WORD_W = 32;
    localparam int RAM_IDX_W = $clog2(RAM_WORDS);
    localparam logic [BUS_AW-1:0] RAM_BYTES = 64'(RAM_WORDS * 4);

    // Memory-mapped peripherals
    localparam logic [BUS_AW-1:0] CON_ADDR = 64'h0000_0000_8000_0000;
    localparam logic [BUS_AW-1:0] KEY_ADDR = 64'h0000_0000_8000_0010;

    // Answer for anything outside the map
    localparam logic [BUS_DW-1:0] UNMAPPED_DATA = 64'hDEADBEEF_DEADBEEF;

endpackage

//--- ps2/ps2_rx.sv
`timescale 1ns/1ps

module ps2_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       rx_err
);
    import kbd_pkg::*;

    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic clk_prev;
    logic fall;
    logic [3:0] bit_cnt;
    logic [9:0] shreg;
    logic [PS2_IDLE_W-1:0] idle_cnt;
    logic last_bit;
    logic frame_ok;

    // Two-flop synchronisers for both lines
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
        end
    end

    // Registered falling-edge strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_prev <= 1'b1;
            fall <= 1'b0;
        end else begin
            clk_prev <= clk_sync[1];
            fall <= clk_prev && !clk_sync[1];
        end
    end

    assign last_bit = (bit_cnt == 4'(PS2_FRAME_BITS - 1));

    // shreg[0] start, shreg[8:1] data, shreg[9] parity, stop bit is the live sample
    assign frame_ok = !shreg[0] && dat_sync[1] && (^shreg[9:1]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            idle_cnt <= '0;
            rx_valid <= 1'b0;
            rx_err <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            rx_err <= 1'b0;
            if (fall) begin
                idle_cnt <= '0;
                if (last_bit) begin
                    bit_cnt <= '0;
                    rx_valid <= frame_ok;
                    rx_err <= !frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != '0) begin
                // Stalled frame is dropped quietly
                if (idle_cnt == PS2_IDLE_W'(PS2_IDLE_CYCLES - 1)) begin
                    bit_cnt <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge clk) begin
        if (fall && !last_bit) begin
            shreg <= {dat_sync[1], shreg[9:1]};
        end
        if (fall && last_bit) begin
            rx_byte <= shreg[8:1];
        end
    end

endmodule

//--- ps2/scan_decoder.sv
`timescale 1ns/1ps

module scan_decoder (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    input  logic       rx_err,
    key_if.src         ev
);
    import kbd_pkg::*;

    logic brk_pend;
    logic ext_pend;
    logic is_break;
    logic is_ext;
    logic emit;

    assign is_break = (rx_byte == BREAK_CODE);
    assign is_ext = (rx_byte == EXT_CODE);

    // Plain data byte with no extended prefix in front of it
    assign emit = rx_valid && !is_break && !is_ext && !ext_pend;

    // Prefix tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            brk_pend <= 1'b0;
            ext_pend <= 1'b0;
        end else if (rx_err) begin
            brk_pend <= 1'b0;
            ext_pend <= 1'b0;
        end else if (rx_valid) begin
            if (is_break) begin
                brk_pend <= 1'b1;
            end else if (is_ext) begin
                ext_pend <= 1'b1;
            end else begin
                // Data byte ends any prefix sequence
                brk_pend <= 1'b0;
                ext_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ev.valid <= 1'b0;
        end else begin
            ev.valid <= emit;
        end
    end

    // Event payload
    always_ff @(posedge clk) begin
        if (emit) begin
            ev.scan <= rx_byte;
            ev.ascii <= scan_to_ascii(rx_byte);
            ev.make <= !brk_pend;
            ev.brk <= brk_pend;
        end
    end

endmodule

//--- sim.f
common/soc_map_pkg.sv
common/kbd_pkg.sv
common/key_if.sv
ps2/ps2_rx.sv
ps2/scan_decoder.sv
verilog/key_irq.sv
verilog/system_bus.sv
verilog/kbd_bus_top.sv
bench/kbd_bus_chk.sv
bench/tb_kbd_bus.sv

//--- verilog/kbd_bus_top.sv
`timescale 1ns/1ps

module kbd_bus_top (
    input  logic                           CLOCK_50,
    input  logic                           KEY0,
    input  logic                           PS2_CLK,
    input  logic                           PS2_DAT,
    input  logic [soc_map_pkg::BUS_AW-1:0] bus_address,
    input  logic [soc_map_pkg::BUS_DW-1:0] bus_write_data,
    input  logic                           bus_write_enable,
    input  logic                           bus_read_enable,
    output logic [soc_map_pkg::BUS_DW-1:0] bus_read_data,
    output logic [kbd_pkg::IRQ_W-1:0]      irq_vector,
    output logic [7:0]                     uart_data,
    output logic                           uart_write
);

    logic [7:0] rx_byte;
    logic rx_valid;
    logic rx_err;
    logic [7:0] key_ascii;

    key_if key_ev ();

    // Keyboard pipeline
    ps2_rx ps2_rx0 (
        .clk      (CLOCK_50),
        .rst_n    (KEY0),
        .ps2_clk  (PS2_CLK),
        .ps2_dat  (PS2_DAT),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .rx_err   (rx_err)
    );

    scan_decoder scan_decoder0 (
        .clk      (CLOCK_50),
        .rst_n    (KEY0),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .rx_err   (rx_err),
        .ev       (key_ev.src)
    );

    key_irq key_irq0 (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .ev         (key_ev.dst),
        .key_ascii  (key_ascii),
        .irq_vector (irq_vector)
    );

    // Memory bus
    system_bus system_bus0 (
        .clk          (CLOCK_50),
        .rst_n        (KEY0),
        .address      (bus_address),
        .write_data   (bus_write_data),
        .write_enable (bus_write_enable),
        .read_enable  (bus_read_enable),
        .key_ascii    (key_ascii),
        .read_data    (bus_read_data),
        .uart_data    (uart_data),
        .uart_write   (uart_write)
    );

endmodule

//--- verilog/key_irq.sv
`timescale 1ns/1ps

module key_irq (
    input  logic                       clk,
    input  logic                       rst_n,
    key_if.dst                         ev,
    output logic [7:0]                 key_ascii,
    output logic [kbd_pkg::IRQ_W-1:0]  irq_vector
);
    import kbd_pkg::*;

    logic press;
    logic fire;

    assign press = ev.valid && ev.make && !ev.brk;

    // Only printable keys interrupt
    assign fire = press && (ev.ascii != 8'h00);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_ascii <= 8'h00;
            irq_vector <= '0;
        end else begin
            if (press) begin
                key_ascii <= ev.ascii;
            end
            // One-shot vector, never held past a single cycle
            if (fire && irq_vector == '0) begin
                irq_vector <= KEY_IRQ_VEC;
            end else begin
                irq_vector <= '0;
            end
        end
    end

endmodule

//--- verilog/system_bus.sv
`timescale 1ns/1ps

module system_bus (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [soc_map_pkg::BUS_AW-1:0] address,
    input  logic [soc_map_pkg::BUS_DW-1:0] write_data,
    input  logic                           write_enable,
    input  logic                           read_enable,
    input  logic [7:0]                     key_ascii,
    output logic [soc_map_pkg::BUS_DW-1:0] read_data,
    output logic [7:0]                     uart_data,
    output logic                           uart_write
);
    import soc_map_pkg::*;

    logic [RAM_WORD_W-1:0] ram [RAM_WORDS];
    logic [BUS_AW-1:0] ram_off;
    logic [RAM_IDX_W-1:0] ram_idx;
    logic ram_sel;
    logic key_sel;
    logic con_sel;
    logic con_wr;
    logic con_wr_q;
    logic [BUS_DW-1:0] rd_mux;

    // Address decode
    assign ram_off = address - RAM_BASE;
    assign ram_sel = (ram_off < RAM_BYTES);
    assign ram_idx = ram_off[RAM_IDX_W+1:2];
    assign key_sel = (address == KEY_ADDR);
    assign con_sel = (address == CON_ADDR);

    always_ff @(posedge clk) begin
        if (write_enable && ram_sel) begin
            ram[ram_idx] <= write_data[RAM_WORD_W-1:0];
        end
    end

    // Console port reads back as unmapped
    always_comb begin
        if (ram_sel) begin
            rd_mux = {{(BUS_DW - RAM_WORD_W){1'b0}}, ram[ram_idx]};
        end else if (key_sel) begin
            rd_mux = {{(BUS_DW - 8){1'b0}}, key_ascii};
        end else begin
            rd_mux = UNMAPPED_DATA;
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if (read_enable) begin
            read_data <= rd_mux;
        end
    end

    // Console strobe on the first cycle of a write run
    assign con_wr = write_enable && con_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            con_wr_q <= 1'b0;
        end else begin
            con_wr_q <= con_wr;
        end
    end

    assign uart_write = con_wr && !con_wr_q;
    assign uart_data = write_data[7:0];

endmodule
